// ==== tests/user_logic_input.txt ====
# columns: test name, command, hex value
# W scans a byte as user DR, N scans it with ir_is_user low, R reads and compares the count
reset_read R 0000
left_to_zero W 4c
left_to_zero W 35
left_to_zero W 30
left_to_zero W 0a
left_to_zero R 0001
full_turn W 52
full_turn W 31
full_turn W 30
full_turn W 30
full_turn W 0a
full_turn R 0002
large_wrap W 52
large_wrap W 31
large_wrap W 32
large_wrap W 33
large_wrap W 34
large_wrap W 0a
large_wrap W 4c
large_wrap W 31
large_wrap W 0a
carriage_return W 52
carriage_return W 36
carriage_return W 37
carriage_return W 0d
carriage_return W 0a
carriage_return R 0003
malformed W 58
malformed W 35
malformed W 0a
malformed W 4c
malformed W 30
malformed W 0a
malformed R 0004
other_instr N 52
other_instr N 31
other_instr N 30
other_instr N 30
other_instr N 0a
other_instr R 0004
second_read R 0004

// ==== build.f ====
hdl/dial_pkg.sv
hdl/jtag_dr_if.sv
hdl/tap_decoder.sv
hdl/ascii_decoder.sv
hdl/dial_tracker.sv
hdl/tap_encoder.sv
hdl/user_logic.sv
tests/tb_clock.sv
tests/user_logic_tb.sv

// ==== Bender.yml ====
package:
  name: user_logic

sources:
  - hdl/dial_pkg.sv
  - hdl/jtag_dr_if.sv
  - hdl/tap_decoder.sv
  - hdl/ascii_decoder.sv
  - hdl/dial_tracker.sv
  - hdl/tap_encoder.sv
  - hdl/user_logic.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/user_logic_tb.sv

// ==== tests/user_logic_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module user_logic_tb;

    localparam int count_width  = 16;
    localparam int byte_width   = 8;
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 4; // lets a newline reach the hold register before a read

    logic tck;
    logic test_logic_reset;
    logic tdi;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    string                  test_names[$];
    string                  test_cmds[$];
    logic [count_width-1:0] test_values[$];

    int unsigned file_lines   = 0;
    int unsigned cycle_count  = 0;
    int unsigned cycle_limit  = 100;
    int unsigned read_checks  = 0;
    int unsigned value_errors = 0;
    int unsigned other_errors = 0;

    tb_clock #(.period_ns(8.0)) clock_gen (
        .tck (tck)
    );

    user_logic u_dut (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .tdi              (tdi),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    // every task starts right after a falling edge and returns right after one
    task automatic scan_byte(input logic [byte_width-1:0] data, input logic user);
        ir_is_user = user;
        shift_dr   = 1'b1;
        tdi        = data[0]; // LSB goes first
        for (int i = 1; i < byte_width; i++) begin
            @(negedge tck);
            tdi = data[i];
        end
        @(negedge tck);
        shift_dr  = 1'b0;
        tdi       = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr  = 1'b0;
        ir_is_user = 1'b0;
        repeat (idle_cycles) @(negedge tck);
    endtask

    task automatic read_count(output logic [count_width-1:0] data);
        logic [count_width-1:0] bits;
        bits       = '0;
        ir_is_user = 1'b1;
        capture_dr = 1'b1;
        for (int i = 0; i < count_width; i++) begin
            @(negedge tck);
            bits[i]    = tdo; // tdo only moves on the rising edge
            capture_dr = 1'b0;
            shift_dr   = 1'b1;
        end
        @(negedge tck);
        shift_dr   = 1'b0;
        ir_is_user = 1'b0;
        data       = bits;
    endtask

    task automatic compare_count(input string name, input logic [count_width-1:0] expected);
        logic [count_width-1:0] actual;
        read_count(actual);
        read_checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR %s: expected %04h, actual %04h", name, expected, actual);
        end
    endtask

    always @(posedge tck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int                     fd;
        int                     n;
        int                     fields;
        string                  line;
        string                  name;
        string                  cmd;
        logic [count_width-1:0] value;

        test_logic_reset = 1'b1;
        tdi              = 1'b0;
        ir_is_user       = 1'b0;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;

        fd = $fopen("tests/user_logic_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/user_logic_input.txt for reading");
            $display("Verification failed");
            $finish;
        end else begin
            n = $fgets(line, fd);
            while (n != 0) begin
                file_lines++;
                fields = $sscanf(line, "%s %s %h", name, cmd, value);
                if (line.getc(0) != "#" && fields == 3) begin
                    test_names.push_back(name);
                    test_cmds.push_back(cmd);
                    test_values.push_back(value);
                end else if (line.getc(0) != "#" && fields > 0) begin
                    other_errors++;
                    $display("line %0d of the data file is not understood", file_lines);
                end
                n = $fgets(line, fd);
            end
            $fclose(fd);
            cycle_limit = file_lines * 40 + 100;

            repeat (reset_cycles) @(negedge tck);
            test_logic_reset = 1'b0;

            foreach (test_cmds[i]) begin
                if (test_cmds[i] == "W") begin
                    scan_byte(test_values[i][byte_width-1:0], 1'b1);
                end else if (test_cmds[i] == "N") begin
                    scan_byte(test_values[i][byte_width-1:0], 1'b0); // some other instruction
                end else if (test_cmds[i] == "R") begin
                    compare_count(test_names[i], test_values[i]);
                end else begin
                    other_errors++;
                    $display("test %s has an unknown command %s", test_names[i], test_cmds[i]);
                end
            end

            $display("reads checked %0d, value errors %0d, other errors %0d",
                     read_checks, value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 8.0
) (
    output logic tck
);

    // starts low so the first rising edge falls half a period in
    initial begin
        tck = 1'b0;
        forever begin
            #(period_ns / 2.0) tck = ~tck;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/user_logic.sv ====
`timescale 1ns/10ps
`default_nettype none

module user_logic import dial_pkg::*; (
    input  logic tck,
    input  logic test_logic_reset,
    input  logic tdi,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    localparam int data_width  = 8;
    localparam int count_width = 16;

    logic [data_width-1:0]  byte_data;
    logic                   byte_valid;
    logic [steps_width-1:0] right_steps;
    logic                   right_steps_valid;
    logic [count_width-1:0] zero_count;
    logic                   zero_count_valid;

    jtag_dr_if dr_if_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset)
    );

    // the TAP strobes come in as plain pins and are bundled here
    assign dr_if_i.tdi        = tdi;
    assign dr_if_i.ir_is_user = ir_is_user;
    assign dr_if_i.capture_dr = capture_dr;
    assign dr_if_i.shift_dr   = shift_dr;
    assign dr_if_i.update_dr  = update_dr;
    assign tdo                = dr_if_i.tdo;

    tap_decoder #(.data_width(data_width)) tap_decoder_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .dr               (dr_if_i.decoder),
        .byte_data        (byte_data),
        .byte_valid       (byte_valid)
    );

    ascii_decoder #(.data_width(data_width)) ascii_decoder_i (
        .tck               (tck),
        .test_logic_reset  (test_logic_reset),
        .byte_data         (byte_data),
        .byte_valid        (byte_valid),
        .right_steps       (right_steps),
        .right_steps_valid (right_steps_valid)
    );

    dial_tracker #(.count_width(count_width)) dial_tracker_i (
        .tck               (tck),
        .test_logic_reset  (test_logic_reset),
        .right_steps       (right_steps),
        .right_steps_valid (right_steps_valid),
        .zero_count        (zero_count),
        .zero_count_valid  (zero_count_valid)
    );

    tap_encoder #(.count_width(count_width)) tap_encoder_i (
        .tck              (tck),
        .test_logic_reset (test_logic_reset),
        .dr               (dr_if_i.encoder),
        .zero_count       (zero_count),
        .zero_count_valid (zero_count_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/tap_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module tap_encoder #(
    parameter int count_width = 16
) (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    jtag_dr_if.encoder             dr,
    input  logic [count_width-1:0] zero_count,
    input  logic                   zero_count_valid
);

    logic [count_width-1:0] hold_reg;
    logic [count_width-1:0] shift_reg;
    logic                   user_capture;
    logic                   user_shift;

    assign user_capture = dr.ir_is_user && dr.capture_dr;
    assign user_shift   = dr.ir_is_user && dr.shift_dr;

    // keeps the newest count until the host asks for it
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            hold_reg <= '0;
        end else if (zero_count_valid) begin
            hold_reg <= zero_count;
        end
    end

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            shift_reg <= '0;
        end else if (user_capture) begin
            shift_reg <= hold_reg;
        end else if (user_shift) begin
            shift_reg <= {1'b0, shift_reg[count_width-1:1]}; // LSB leaves first
        end
    end

    assign dr.tdo = shift_reg[0];

endmodule

`default_nettype wire

// ==== hdl/dial_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module dial_tracker import dial_pkg::*; #(
    parameter int count_width = 16
) (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    input  logic [steps_width-1:0] right_steps,
    input  logic                   right_steps_valid,
    output logic [count_width-1:0] zero_count,
    output logic                   zero_count_valid
);

    logic [steps_width-1:0] position;
    logic                   position_valid;
    logic [steps_width:0]   next_sum; // one extra bit, two folded values stay below 200

    assign next_sum = {1'b0, position} + {1'b0, right_steps};

    // both inputs are below dial_size, so one subtraction is always enough
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            position       <= dial_start;
            position_valid <= 1'b0;
        end else begin
            position_valid <= right_steps_valid;
            if (right_steps_valid) begin
                if (next_sum >= (steps_width + 1)'(dial_size)) begin
                    position <= steps_width'(next_sum - (steps_width + 1)'(dial_size));
                end else begin
                    position <= next_sum[steps_width-1:0];
                end
            end
        end
    end

    // counts on the cycle after the move, so a new step can be taken every cycle
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            zero_count       <= '0;
            zero_count_valid <= 1'b0;
        end else begin
            zero_count_valid <= position_valid;
            if (position_valid && position == '0) begin
                zero_count <= zero_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ascii_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module ascii_decoder import dial_pkg::*; #(
    parameter int data_width = 8
) (
    input  logic                   tck,
    input  logic                   test_logic_reset,
    input  logic [data_width-1:0]  byte_data,
    input  logic                   byte_valid,
    output logic [steps_width-1:0] right_steps,
    output logic                   right_steps_valid
);

    // 99 * 10 + 9 is the largest value before folding
    localparam int sum_width = 10;

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_dir    = 2'd1; // letter seen, waiting for the first digit
    localparam logic [1:0] st_digits = 2'd2;

    logic [1:0]             state;
    logic                   is_left;
    logic [steps_width-1:0] value;
    logic [sum_width-1:0]   digit_sum;
    logic [steps_width-1:0] folded;
    logic                   is_digit;
    logic                   is_dir;
    logic                   is_lf;
    logic                   is_cr;

    // brings a value below 1000 back under dial_size
    function automatic logic [steps_width-1:0] fold(input logic [sum_width-1:0] sum);
        logic [sum_width-1:0] rest;
        rest = sum;
        for (int k = 9; k >= 1; k--) begin
            if (rest >= sum_width'(k * dial_size)) begin
                rest = rest - sum_width'(k * dial_size);
            end
        end
        return rest[steps_width-1:0];
    endfunction

    assign is_digit = (byte_data >= ascii_zero) && (byte_data <= ascii_nine);
    assign is_dir   = (byte_data == ascii_l) || (byte_data == ascii_r);
    assign is_lf    = byte_data == ascii_lf;
    assign is_cr    = byte_data == ascii_cr;

    // the digit value sits in the low nibble of its ASCII code
    assign digit_sum = sum_width'(value) * sum_width'(10) + sum_width'(byte_data[3:0]);
    assign folded    = fold(digit_sum);

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            state             <= st_idle;
            right_steps_valid <= 1'b0;
        end else begin
            right_steps_valid <= 1'b0;
            if (byte_valid && !is_cr) begin // carriage returns pass by unseen
                case (state)
                    st_idle: begin
                        if (is_dir) begin
                            state <= st_dir;
                        end
                    end
                    st_dir: begin
                        state <= is_digit ? st_digits : st_idle;
                    end
                    st_digits: begin
                        if (is_lf) begin
                            right_steps_valid <= 1'b1;
                            state             <= st_idle;
                        end else if (!is_digit) begin
                            state <= st_idle; // anything else drops the line
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge tck) begin
        if (byte_valid) begin
            if (state == st_idle && is_dir) begin
                is_left <= byte_data == ascii_l;
                value   <= '0;
            end else if (state != st_idle && is_digit) begin
                value <= folded;
            end
            // a left turn by n is a right turn by dial_size - n
            if (state == st_digits && is_lf) begin
                if (!is_left || value == '0) begin
                    right_steps <= value;
                end else begin
                    right_steps <= steps_width'(dial_size - value);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module tap_decoder #(
    parameter int data_width = 8
) (
    input  logic                  tck,
    input  logic                  test_logic_reset,
    jtag_dr_if.decoder            dr,
    output logic [data_width-1:0] byte_data,
    output logic                  byte_valid
);

    logic [data_width-1:0] shift_reg;
    logic                  user_shift;
    logic                  user_update;

    assign user_shift  = dr.ir_is_user && dr.shift_dr;
    assign user_update = dr.ir_is_user && dr.update_dr;

    // bits arrive LSB first, so each new one enters at the top and walks down
    // towards bit 0; extra bits simply push the oldest ones out
    always_ff @(posedge tck) begin
        if (user_shift) begin
            shift_reg <= {dr.tdi, shift_reg[data_width-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (user_update) begin
            byte_data <= shift_reg; // stays put while the next byte is scanned in
        end
    end

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= user_update;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/jtag_dr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface jtag_dr_if (
    input logic tck,
    input logic test_logic_reset
);

    logic tdi;
    logic tdo;
    logic ir_is_user; // user instruction is loaded in the IR
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    // inbound side, turns scanned bits into bytes
    modport decoder (
        input tck,
        input test_logic_reset,
        input tdi,
        input ir_is_user,
        input shift_dr,
        input update_dr
    );

    modport encoder (
        input  tck,
        input  test_logic_reset,
        input  ir_is_user,
        input  capture_dr,
        input  shift_dr,
        output tdo
    );

endinterface

`default_nettype wire

// ==== hdl/dial_pkg.sv ====
`default_nettype none

package dial_pkg;

    // the dial shows positions 0 to dial_size - 1
    localparam int unsigned dial_size = 100;

    // a step count or a position that is already folded below dial_size
    localparam int unsigned steps_width = 7;

    localparam logic [steps_width-1:0] dial_start = 7'd50; // resting position after reset

    // characters the line parser knows about
    localparam logic [7:0] ascii_l    = 8'h4c;
    localparam logic [7:0] ascii_r    = 8'h52;
    localparam logic [7:0] ascii_zero = 8'h30;
    localparam logic [7:0] ascii_nine = 8'h39;
    localparam logic [7:0] ascii_lf   = 8'h0a;
    localparam logic [7:0] ascii_cr   = 8'h0d;

endpackage

`default_nettype wire
